// File: rtl/psl_pkg.sv
////////////////////
// bus side types: address, tag and credit widths,
// command opcodes and response codes
////////////////////

package psl_pkg;

	typedef logic [63:0] ea_t;
	typedef logic [7:0]  tag_t;
	typedef logic [7:0]  credit_t;

	// command opcodes, only the two this core issues
	typedef enum logic [12:0] {
		READ_CL_NA = 13'h0A00,
		WRITE_NA   = 13'h0D00
	} psl_cmd_e;

	// response codes as returned on the response bus
	typedef enum logic [7:0] {
		DONE    = 8'h00,
		AERROR  = 8'h01,
		DERROR  = 8'h03,
		NLOCK   = 8'h04,
		NRES    = 8'h05,
		FLUSHED = 8'h06,
		FAULT   = 8'h07,
		FAILED  = 8'h08,
		PAGED   = 8'h0A
	} psl_rsp_e;

endpackage

// File: rtl/afu_pkg.sv
////////////////////
// accelerator side types: command class
// and compute unit id
////////////////////

package afu_pkg;

	localparam int NUM_CLASSES = 3;

	// class index doubles as queue index
	typedef enum logic [1:0] {
		CLASS_READ  = 2'd0,
		CLASS_WRITE = 2'd1,
		CLASS_WED   = 2'd2
	} cmd_class_e;

	typedef logic [7:0] cu_id_t;

endpackage

// File: rtl/class_queue.sv
////////////////////
// per class command queue, circular buffer
// holding address and cu id
////////////////////
`timescale 1ns/1ps

module class_queue import psl_pkg::*, afu_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic   clock,
	input  logic   rstn,
	input  logic   push,
	input  ea_t    push_address,
	input  cu_id_t push_cu_id,
	input  logic   pop,
	output ea_t    head_address,
	output cu_id_t head_cu_id,
	output logic   not_empty,
	output logic   full
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	ea_t    address_mem [QUEUE_DEPTH];
	cu_id_t cu_id_mem   [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// push into a full queue is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && not_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// wrap by compare, depth need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// entry storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			address_mem[wr_ptr] <= push_address;
			cu_id_mem[wr_ptr]   <= push_cu_id;
		end
	end

	// head is visible the cycle after the push
	assign head_address = address_mem[rd_ptr];
	assign head_cu_id   = cu_id_mem[rd_ptr];
	assign not_empty    = (count != '0);
	assign full         = (count == CNT_W'(QUEUE_DEPTH));

endmodule

// File: rtl/cmd_arbiter.sv
////////////////////
// round robin pick across the class queues,
// gated by enable, credits and tag pool
////////////////////
`timescale 1ns/1ps

module cmd_arbiter import psl_pkg::*, afu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic [NUM_CLASSES-1:0] not_empty,
	input  ea_t                    head_address [NUM_CLASSES],
	input  cu_id_t                 head_cu_id   [NUM_CLASSES],
	input  logic                   read_credit_ok,
	input  logic                   write_credit_ok,
	input  logic                   total_credit_ok,
	input  logic                   tag_free,
	output logic [NUM_CLASSES-1:0] pop,
	output logic                   issue_valid,
	output cmd_class_e             issue_class,
	output ea_t                    issue_address,
	output cu_id_t                 issue_cu_id
);

	logic [NUM_CLASSES-1:0] eligible;
	logic                   can_pick;
	logic                   pick;
	cmd_class_e             pick_class;
	cmd_class_e             last_grant;

	// wed has no class credit of its own
	assign eligible[CLASS_READ]  = not_empty[CLASS_READ] && read_credit_ok;
	assign eligible[CLASS_WRITE] = not_empty[CLASS_WRITE] && write_credit_ok;
	assign eligible[CLASS_WED]   = not_empty[CLASS_WED];

	// no pick while an issue is in flight, so the
	// credit counts and tag pool have caught up
	assign can_pick = enabled && tag_free && total_credit_ok && !issue_valid;

	////////////////////
	// grant search
	////////////////////
	always_comb begin
		int slot;
		pick       = 1'b0;
		pick_class = last_grant;
		// start one past the last winner
		for (int off = 1; off <= NUM_CLASSES; off++) begin
			slot = (int'(last_grant) + off) % NUM_CLASSES;
			if (!pick && eligible[slot]) begin
				pick       = 1'b1;
				pick_class = cmd_class_e'(slot);
			end
		end
		pick = pick && can_pick;
		pop  = '0;
		if (pick) begin
			pop[pick_class] = 1'b1;
		end
	end

	// control state
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_valid <= 1'b0;
			// read goes first after reset
			last_grant  <= CLASS_WED;
		end else begin
			issue_valid <= pick;
			if (pick) begin
				last_grant <= pick_class;
			end
		end
	end

	// winner's head, one cycle after the pop
	always_ff @(posedge clock) begin
		if (pick) begin
			issue_class   <= pick_class;
			issue_address <= head_address[pick_class];
			issue_cu_id   <= head_cu_id[pick_class];
		end
	end

endmodule

// File: rtl/tag_control.sv
////////////////////
// free tag pool and per tag table of
// class and cu id
////////////////////
`timescale 1ns/1ps

module tag_control import psl_pkg::*, afu_pkg::*; #(
	parameter int NUM_TAGS = 16
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       issue_valid,
	input  cmd_class_e issue_class,
	input  cu_id_t     issue_cu_id,
	output tag_t       issue_tag,
	output logic       tag_free,
	input  logic       lookup_valid,
	input  tag_t       lookup_tag,
	output logic       found_valid,
	output cmd_class_e found_class,
	output cu_id_t     found_cu_id
);

	localparam int IDX_W = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

	logic [NUM_TAGS-1:0] busy;
	cmd_class_e          class_table [NUM_TAGS];
	cu_id_t              cu_id_table [NUM_TAGS];
	logic [IDX_W-1:0]    free_idx;
	logic [IDX_W-1:0]    lookup_idx;
	logic                release_tag;

	// lowest free tag, scanned from the top down
	always_comb begin
		free_idx = '0;
		for (int t = NUM_TAGS - 1; t >= 0; t--) begin
			if (!busy[t]) begin
				free_idx = IDX_W'(t);
			end
		end
	end

	assign tag_free  = ~&busy;
	assign issue_tag = tag_t'(free_idx);

	// unknown or idle tags are ignored
	assign lookup_idx  = lookup_tag[IDX_W-1:0];
	assign release_tag = lookup_valid && (lookup_tag < NUM_TAGS) && busy[lookup_idx];

	////////////////////
	// busy bits
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy        <= '0;
			found_valid <= 1'b0;
		end else begin
			found_valid <= release_tag;
			// release and allocate never hit the same tag
			if (release_tag) begin
				busy[lookup_idx] <= 1'b0;
			end
			if (issue_valid) begin
				busy[free_idx] <= 1'b1;
			end
		end
	end

	// table write on issue, read on lookup
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			class_table[free_idx] <= issue_class;
			cu_id_table[free_idx] <= issue_cu_id;
		end
		found_class <= class_table[lookup_idx];
		found_cu_id <= cu_id_table[lookup_idx];
	end

endmodule

// File: rtl/credit_control.sv
////////////////////
// saturating credit counter
////////////////////
`timescale 1ns/1ps

module credit_control import psl_pkg::*; #(
	parameter int LIMIT = 8
) (
	input  logic    clock,
	input  logic    rstn,
	input  logic    take,
	input  logic    give,
	input  credit_t give_amount,
	output logic    available
);

	localparam int W = $bits(credit_t);

	credit_t      count;
	logic [W:0]   next_count;

	// one spare bit so a large return cannot wrap
	always_comb begin
		next_count = {1'b0, count} - {{W{1'b0}}, take};
		if (give) begin
			next_count = next_count + {1'b0, give_amount};
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= credit_t'(LIMIT);
		end else if (next_count > LIMIT) begin
			// cap at the limit
			count <= credit_t'(LIMIT);
		end else begin
			count <= next_count[W-1:0];
		end
	end

	assign available = (count != '0);

endmodule

// File: rtl/rsp_route.sv
////////////////////
// response capture, tag lookup, fixed delay
// line and per class response strobes
////////////////////
`timescale 1ns/1ps

module rsp_route import psl_pkg::*, afu_pkg::*; #(
	parameter int RSP_DELAY = 4
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled,
	input  logic       rsp_valid,
	input  tag_t       rsp_tag,
	input  psl_rsp_e   rsp_code,
	input  credit_t    rsp_credits,
	output logic       lookup_valid,
	output tag_t       lookup_tag,
	input  logic       found_valid,
	input  cmd_class_e found_class,
	input  cu_id_t     found_cu_id,
	output logic       read_rsp_valid,
	output cu_id_t     read_rsp_cu_id,
	output psl_rsp_e   read_rsp_code,
	output logic       write_rsp_valid,
	output cu_id_t     write_rsp_cu_id,
	output psl_rsp_e   write_rsp_code,
	output logic       wed_rsp_valid,
	output cu_id_t     wed_rsp_cu_id,
	output psl_rsp_e   wed_rsp_code,
	output logic       credit_return_valid,
	output credit_t    credit_return_amount,
	output cmd_class_e credit_return_class
);

	localparam int LAST = RSP_DELAY - 1;

	// code and credits ride beside the lookup
	psl_rsp_e code_d1;
	psl_rsp_e code_d2;
	credit_t  credits_d1;
	credit_t  credits_d2;

	// delay line, one entry per stage
	logic       dly_valid [RSP_DELAY];
	cmd_class_e dly_class [RSP_DELAY];
	cu_id_t     dly_cu_id [RSP_DELAY];
	psl_rsp_e   dly_code  [RSP_DELAY];
	credit_t    dly_credits [RSP_DELAY];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lookup_valid <= 1'b0;
			for (int s = 0; s < RSP_DELAY; s++) begin
				dly_valid[s] <= 1'b0;
			end
		end else begin
			// disabled: responses are dropped at the door
			lookup_valid <= enabled && rsp_valid;
			dly_valid[0] <= found_valid;
			for (int s = 1; s < RSP_DELAY; s++) begin
				dly_valid[s] <= dly_valid[s-1];
			end
		end
	end

	////////////////////
	// payload pipeline
	////////////////////
	always_ff @(posedge clock) begin
		lookup_tag     <= rsp_tag;
		code_d1        <= rsp_code;
		credits_d1     <= rsp_credits;
		code_d2        <= code_d1;
		credits_d2     <= credits_d1;
		dly_class[0]   <= found_class;
		dly_cu_id[0]   <= found_cu_id;
		dly_code[0]    <= code_d2;
		dly_credits[0] <= credits_d2;
		for (int s = 1; s < RSP_DELAY; s++) begin
			dly_class[s]   <= dly_class[s-1];
			dly_cu_id[s]   <= dly_cu_id[s-1];
			dly_code[s]    <= dly_code[s-1];
			dly_credits[s] <= dly_credits[s-1];
		end
	end

	// strobe per class off the last stage
	assign read_rsp_valid  = dly_valid[LAST] && (dly_class[LAST] == CLASS_READ);
	assign write_rsp_valid = dly_valid[LAST] && (dly_class[LAST] == CLASS_WRITE);
	assign wed_rsp_valid   = dly_valid[LAST] && (dly_class[LAST] == CLASS_WED);
	assign read_rsp_cu_id  = dly_cu_id[LAST];
	assign write_rsp_cu_id = dly_cu_id[LAST];
	assign wed_rsp_cu_id   = dly_cu_id[LAST];
	assign read_rsp_code   = dly_code[LAST];
	assign write_rsp_code  = dly_code[LAST];
	assign wed_rsp_code    = dly_code[LAST];

	assign credit_return_valid  = dly_valid[LAST];
	assign credit_return_amount = dly_credits[LAST];
	assign credit_return_class  = dly_class[LAST];

endmodule

// File: rtl/afu_control.sv
////////////////////
// command and response core top: queues, arbiter,
// tag pool, credit counters, response routing
////////////////////
`timescale 1ns/1ps

module afu_control import psl_pkg::*, afu_pkg::*; #(
	parameter int QUEUE_DEPTH   = 8,
	parameter int NUM_TAGS      = 16,
	parameter int TOTAL_CREDITS = 8,
	parameter int READ_CREDITS  = 4,
	parameter int WRITE_CREDITS = 4,
	parameter int RSP_DELAY     = 4
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled_in,
	input  logic     read_valid,
	input  ea_t      read_address,
	input  cu_id_t   read_cu_id,
	output logic     read_full,
	input  logic     write_valid,
	input  ea_t      write_address,
	input  cu_id_t   write_cu_id,
	output logic     write_full,
	input  logic     wed_valid,
	input  ea_t      wed_address,
	input  cu_id_t   wed_cu_id,
	output logic     wed_full,
	output logic     cmd_out_valid,
	output psl_cmd_e cmd_out_opcode,
	output ea_t      cmd_out_address,
	output tag_t     cmd_out_tag,
	input  logic     rsp_valid,
	input  tag_t     rsp_tag,
	input  psl_rsp_e rsp_code,
	input  credit_t  rsp_credits,
	output logic     read_rsp_valid,
	output cu_id_t   read_rsp_cu_id,
	output psl_rsp_e read_rsp_code,
	output logic     write_rsp_valid,
	output cu_id_t   write_rsp_cu_id,
	output psl_rsp_e write_rsp_code,
	output logic     wed_rsp_valid,
	output cu_id_t   wed_rsp_cu_id,
	output psl_rsp_e wed_rsp_code
);

	logic                   enabled;
	logic [NUM_CLASSES-1:0] q_push;
	logic [NUM_CLASSES-1:0] q_pop;
	logic [NUM_CLASSES-1:0] q_not_empty;
	logic [NUM_CLASSES-1:0] q_full;
	ea_t                    q_push_address [NUM_CLASSES];
	cu_id_t                 q_push_cu_id   [NUM_CLASSES];
	ea_t                    q_head_address [NUM_CLASSES];
	cu_id_t                 q_head_cu_id   [NUM_CLASSES];

	logic       issue_valid;
	cmd_class_e issue_class;
	ea_t        issue_address;
	cu_id_t     issue_cu_id;
	tag_t       issue_tag;
	logic       tag_free;
	logic       read_credit_ok;
	logic       write_credit_ok;
	logic       total_credit_ok;
	logic       lookup_valid;
	tag_t       lookup_tag;
	logic       found_valid;
	cmd_class_e found_class;
	cu_id_t     found_cu_id;
	logic       ret_valid;
	credit_t    ret_amount;
	cmd_class_e ret_class;

	// enable is taken one cycle late
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////
	// class queues
	////////////////////
	assign q_push                      = {wed_valid, write_valid, read_valid};
	assign q_push_address[CLASS_READ]  = read_address;
	assign q_push_address[CLASS_WRITE] = write_address;
	assign q_push_address[CLASS_WED]   = wed_address;
	assign q_push_cu_id[CLASS_READ]    = read_cu_id;
	assign q_push_cu_id[CLASS_WRITE]   = write_cu_id;
	assign q_push_cu_id[CLASS_WED]     = wed_cu_id;
	assign {wed_full, write_full, read_full} = q_full;

	for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_queue
		class_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) class_queue_i (
			.clock       (clock),
			.rstn        (rstn),
			.push        (q_push[c]),
			.push_address(q_push_address[c]),
			.push_cu_id  (q_push_cu_id[c]),
			.pop         (q_pop[c]),
			.head_address(q_head_address[c]),
			.head_cu_id  (q_head_cu_id[c]),
			.not_empty   (q_not_empty[c]),
			.full        (q_full[c])
		);
	end

	cmd_arbiter cmd_arbiter_i (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.not_empty(q_not_empty), .head_address(q_head_address), .head_cu_id(q_head_cu_id),
		.read_credit_ok(read_credit_ok), .write_credit_ok(write_credit_ok),
		.total_credit_ok(total_credit_ok), .tag_free(tag_free), .pop(q_pop),
		.issue_valid(issue_valid), .issue_class(issue_class),
		.issue_address(issue_address), .issue_cu_id(issue_cu_id)
	);

	tag_control #(.NUM_TAGS(NUM_TAGS)) tag_control_i (
		.clock(clock), .rstn(rstn),
		.issue_valid(issue_valid), .issue_class(issue_class), .issue_cu_id(issue_cu_id),
		.issue_tag(issue_tag), .tag_free(tag_free),
		.lookup_valid(lookup_valid), .lookup_tag(lookup_tag),
		.found_valid(found_valid), .found_class(found_class), .found_cu_id(found_cu_id)
	);

	// command bus, write class goes out as write_na
	assign cmd_out_valid   = issue_valid;
	assign cmd_out_opcode  = (issue_class == CLASS_WRITE) ? WRITE_NA : READ_CL_NA;
	assign cmd_out_address = issue_address;
	assign cmd_out_tag     = issue_tag;

	////////////////////
	// credits
	////////////////////
	credit_control #(.LIMIT(TOTAL_CREDITS)) total_credit_i (
		.clock(clock), .rstn(rstn), .take(issue_valid),
		.give(ret_valid), .give_amount(ret_amount), .available(total_credit_ok)
	);

	// class counts move by one per command
	credit_control #(.LIMIT(READ_CREDITS)) read_credit_i (
		.clock(clock), .rstn(rstn),
		.take(issue_valid && (issue_class == CLASS_READ)),
		.give(ret_valid && (ret_class == CLASS_READ)),
		.give_amount(credit_t'(1)), .available(read_credit_ok)
	);

	credit_control #(.LIMIT(WRITE_CREDITS)) write_credit_i (
		.clock(clock), .rstn(rstn),
		.take(issue_valid && (issue_class == CLASS_WRITE)),
		.give(ret_valid && (ret_class == CLASS_WRITE)),
		.give_amount(credit_t'(1)), .available(write_credit_ok)
	);

	rsp_route #(.RSP_DELAY(RSP_DELAY)) rsp_route_i (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_code(rsp_code),
		.rsp_credits(rsp_credits), .lookup_valid(lookup_valid), .lookup_tag(lookup_tag),
		.found_valid(found_valid), .found_class(found_class), .found_cu_id(found_cu_id),
		.read_rsp_valid(read_rsp_valid), .read_rsp_cu_id(read_rsp_cu_id),
		.read_rsp_code(read_rsp_code), .write_rsp_valid(write_rsp_valid),
		.write_rsp_cu_id(write_rsp_cu_id), .write_rsp_code(write_rsp_code),
		.wed_rsp_valid(wed_rsp_valid), .wed_rsp_cu_id(wed_rsp_cu_id),
		.wed_rsp_code(wed_rsp_code), .credit_return_valid(ret_valid),
		.credit_return_amount(ret_amount), .credit_return_class(ret_class)
	);

endmodule

// File: dv/afu_checker.sv
////////////////////
// reference model and comparisons for the
// command and response core
////////////////////
`timescale 1ns/1ps

module afu_checker import psl_pkg::*, afu_pkg::*; #(
	parameter int QUEUE_DEPTH   = 8,
	parameter int TOTAL_CREDITS = 8,
	parameter int READ_CREDITS  = 4,
	parameter int WRITE_CREDITS = 4,
	parameter int RSP_DELAY     = 4
) (
	input  logic clock, rstn, quiet,
	input  logic read_valid, write_valid, wed_valid,
	input  ea_t read_address, write_address, wed_address,
	input  cu_id_t read_cu_id, write_cu_id, wed_cu_id,
	input  logic read_full, write_full, wed_full,
	input  logic cmd_out_valid,
	input  psl_cmd_e cmd_out_opcode,
	input  ea_t cmd_out_address,
	input  tag_t cmd_out_tag,
	input  logic rsp_valid,
	input  tag_t rsp_tag,
	input  psl_rsp_e rsp_code,
	input  credit_t rsp_credits,
	input  logic read_rsp_valid, write_rsp_valid, wed_rsp_valid,
	input  cu_id_t read_rsp_cu_id, write_rsp_cu_id, wed_rsp_cu_id,
	input  psl_rsp_e read_rsp_code, write_rsp_code, wed_rsp_code,
	output int mismatch_count,
	output int other_count
);

	// expected {address, cu id} per class
	logic [71:0] cmd_q [NUM_CLASSES][$];
	logic        tag_busy  [256];
	int          tag_class [256];
	cu_id_t      tag_cu    [256];
	// responses in flight through the delay line
	int pend_due [$];
	int pend_class [$];
	cu_id_t pend_cu [$];
	psl_rsp_e pend_code [$];
	int pend_credits [$];
	int cycle;
	int total_out, read_out, write_out;

	logic     push_v [NUM_CLASSES];
	logic     full_v [NUM_CLASSES];
	logic     rsp_v  [NUM_CLASSES];
	cu_id_t   rsp_cu [NUM_CLASSES];
	psl_rsp_e rsp_cd [NUM_CLASSES];
	logic [71:0] push_d [NUM_CLASSES];

	assign push_v = '{read_valid, write_valid, wed_valid};
	assign full_v = '{read_full, write_full, wed_full};
	assign rsp_v  = '{read_rsp_valid, write_rsp_valid, wed_rsp_valid};
	assign rsp_cu = '{read_rsp_cu_id, write_rsp_cu_id, wed_rsp_cu_id};
	assign rsp_cd = '{read_rsp_code, write_rsp_code, wed_rsp_code};
	assign push_d = '{{read_address, read_cu_id}, {write_address, write_cu_id},
		{wed_address, wed_cu_id}};

	task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
		mismatch_count++;
	endtask

	task automatic failure(input string what);
		$display("error: %s", what);
		other_count++;
	endtask

	// leftover model state at the end of the run
	task automatic check_empty();
		for (int c = 0; c < NUM_CLASSES; c++) begin
			if (cmd_q[c].size() != 0) begin
				failure($sformatf("class %0d still holds %0d unissued commands", c,
					cmd_q[c].size()));
			end
		end
		if (pend_due.size() != 0 || total_out != 0) begin
			failure("responses still outstanding at the end");
		end
	endtask

	initial begin
		mismatch_count = 0;
		other_count = 0;
		cycle = 0;
		total_out = 0;
		read_out = 0;
		write_out = 0;
		for (int t = 0; t < 256; t++) begin
			tag_busy[t] = 1'b0;
		end
	end

	always @(posedge clock) begin
		int cls;
		bit exp_any;
		bit exp_v;
		psl_cmd_e exp_op;
		if (rstn) begin
			cycle++;
			// routed strobes against the delay model
			exp_any = pend_due.size() > 0 && pend_due[0] == cycle;
			for (int c = 0; c < NUM_CLASSES; c++) begin
				exp_v = exp_any && pend_class[0] == c;
				if (rsp_v[c] != exp_v) begin
					mismatch($sformatf("rsp_valid[%0d]", c), 64'(exp_v), 64'(rsp_v[c]));
				end else if (exp_v) begin
					if (rsp_cu[c] != pend_cu[0]) begin
						mismatch("rsp_cu_id", 64'(pend_cu[0]), 64'(rsp_cu[c]));
					end
					if (rsp_cd[c] != pend_code[0]) begin
						mismatch("rsp_code", 64'(pend_code[0]), 64'(rsp_cd[c]));
					end
				end
			end
			if (exp_any) begin
				total_out -= pend_credits[0];
				if (pend_class[0] == 0) read_out--;
				if (pend_class[0] == 1) write_out--;
				void'(pend_due.pop_front());
				void'(pend_class.pop_front());
				void'(pend_cu.pop_front());
				void'(pend_code.pop_front());
				void'(pend_credits.pop_front());
			end
			// incoming response looked up by tag
			if (rsp_valid) begin
				if (!tag_busy[rsp_tag]) begin
					failure($sformatf("response for tag %0d which is not outstanding", rsp_tag));
				end else begin
					tag_busy[rsp_tag] = 1'b0;
					pend_due.push_back(cycle + RSP_DELAY + 2);
					pend_class.push_back(tag_class[rsp_tag]);
					pend_cu.push_back(tag_cu[rsp_tag]);
					pend_code.push_back(rsp_code);
					pend_credits.push_back(int'(rsp_credits));
				end
			end
			if (cmd_out_valid) begin
				if (quiet) begin
					failure("command issued while disabled");
				end
				// class of the queue whose oldest unissued address went out
				cls = -1;
				for (int c = NUM_CLASSES - 1; c >= 0; c--) begin
					if (cmd_q[c].size() > 0 && cmd_q[c][0][71:8] == cmd_out_address) begin
						cls = c;
					end
				end
				if (cls < 0) begin
					failure($sformatf("command address %h matches no oldest pending push",
						cmd_out_address));
				end else begin
					// write goes out as write_na, read and wed as read_cl_na
					exp_op = (cls == 1) ? WRITE_NA : READ_CL_NA;
					if (cmd_out_opcode != exp_op) begin
						mismatch("issue_opcode", 64'(exp_op), 64'(cmd_out_opcode));
					end
					if (tag_busy[cmd_out_tag]) begin
						failure($sformatf("tag %0d issued while still outstanding", cmd_out_tag));
					end
					tag_busy[cmd_out_tag] = 1'b1;
					tag_class[cmd_out_tag] = cls;
					tag_cu[cmd_out_tag] = cmd_q[cls][0][7:0];
					void'(cmd_q[cls].pop_front());
				end
				total_out++;
				if (cls == 0) read_out++;
				if (cls == 1) write_out++;
				if (total_out > TOTAL_CREDITS || read_out > READ_CREDITS ||
					write_out > WRITE_CREDITS) begin
					failure("outstanding commands exceed a credit limit");
				end
			end
			for (int c = 0; c < NUM_CLASSES; c++) begin
				if (quiet && full_v[c] != (cmd_q[c].size() == QUEUE_DEPTH)) begin
					mismatch($sformatf("full[%0d]", c), 64'(cmd_q[c].size() == QUEUE_DEPTH),
						64'(full_v[c]));
				end
				if (push_v[c] && !full_v[c]) begin
					cmd_q[c].push_back(push_d[c]);
				end
			end
		end
	end

endmodule

// File: dv/tb_afu_control.sv
////////////////////
// testbench top: clock, reset, lfsr stimulus
// and a responder for outstanding tags
////////////////////
`timescale 1ns/1ps

module tb_afu_control import psl_pkg::*, afu_pkg::*;;

	localparam int QUEUE_DEPTH   = 8;
	localparam int NUM_TAGS      = 16;
	localparam int TOTAL_CREDITS = 8;
	localparam int READ_CREDITS  = 4;
	localparam int WRITE_CREDITS = 4;
	localparam int RSP_DELAY     = 4;
	localparam int RANDOM_CYCLES = 600;
	localparam int DRAIN_LIMIT   = 3000;

	logic clock;
	logic rstn;
	logic enabled_in;
	logic quiet;
	logic read_valid, write_valid, wed_valid;
	ea_t read_address, write_address, wed_address;
	cu_id_t read_cu_id, write_cu_id, wed_cu_id;
	logic read_full, write_full, wed_full;
	logic cmd_out_valid;
	psl_cmd_e cmd_out_opcode;
	ea_t cmd_out_address;
	tag_t cmd_out_tag;
	logic rsp_valid;
	tag_t rsp_tag;
	psl_rsp_e rsp_code;
	credit_t rsp_credits;
	logic read_rsp_valid, write_rsp_valid, wed_rsp_valid;
	cu_id_t read_rsp_cu_id, write_rsp_cu_id, wed_rsp_cu_id;
	psl_rsp_e read_rsp_code, write_rsp_code, wed_rsp_code;
	int mismatch_count;
	int other_count;

	logic [31:0] lfsr;
	tag_t out_tags [$];
	int pushed;
	int issued;

	afu_control #(
		.QUEUE_DEPTH(QUEUE_DEPTH), .NUM_TAGS(NUM_TAGS), .TOTAL_CREDITS(TOTAL_CREDITS),
		.READ_CREDITS(READ_CREDITS), .WRITE_CREDITS(WRITE_CREDITS), .RSP_DELAY(RSP_DELAY)
	) afu_control_i (.*);

	afu_checker #(
		.QUEUE_DEPTH(QUEUE_DEPTH), .TOTAL_CREDITS(TOTAL_CREDITS),
		.READ_CREDITS(READ_CREDITS), .WRITE_CREDITS(WRITE_CREDITS), .RSP_DELAY(RSP_DELAY)
	) afu_checker_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// galois step with taps for a maximal 32 bit sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	function automatic psl_rsp_e code_of(input logic [3:0] idx);
		case (idx % 9)
			0: return DONE;
			1: return AERROR;
			2: return DERROR;
			3: return NLOCK;
			4: return NRES;
			5: return FLUSHED;
			6: return FAULT;
			7: return FAILED;
			default: return PAGED;
		endcase
	endfunction

	// tags the responder may answer
	always @(posedge clock) begin
		if (rstn && cmd_out_valid) begin
			out_tags.push_back(cmd_out_tag);
			issued++;
		end
	end

	// mode 0 random pushes, 1 push every class, 2 no pushes
	task automatic drive_cycle(input int mode, input bit allow_rsp);
		logic [63:0] r;
		logic [63:0] a;
		logic [63:0] id;
		logic go;
		int idx;
		@(posedge clock);
		#2;
		for (int c = 0; c < NUM_CLASSES; c++) begin
			take_bits(2, r);
			take_bits(64, a);
			take_bits(8, id);
			go = (mode == 1) || (mode == 0 && r[1:0] == 2'd0);
			case (c)
				0: begin
					go = go && !read_full;
					read_valid = go;
					read_address = a;
					read_cu_id = id[7:0];
				end
				1: begin
					go = go && !write_full;
					write_valid = go;
					write_address = a;
					write_cu_id = id[7:0];
				end
				default: begin
					go = go && !wed_full;
					wed_valid = go;
					wed_address = a;
					wed_cu_id = id[7:0];
				end
			endcase
			if (go) begin
				pushed++;
			end
		end
		// responder answers after a random gap
		take_bits(16, r);
		rsp_valid = 1'b0;
		if (allow_rsp && out_tags.size() > 0 && r[0]) begin
			idx = int'(r[15:1]) % out_tags.size();
			rsp_tag = out_tags[idx];
			out_tags.delete(idx);
			take_bits(4, r);
			rsp_code = code_of(r[3:0]);
			rsp_credits = credit_t'(1);
			rsp_valid = 1'b1;
		end
	endtask

	// answer until every push has issued and been answered
	task automatic drain(output bit timed_out);
		int waited;
		waited = 0;
		while ((issued != pushed || out_tags.size() != 0) && waited < DRAIN_LIMIT) begin
			drive_cycle(2, 1'b1);
			waited++;
		end
		timed_out = (waited >= DRAIN_LIMIT);
		// tail of the fixed response delay
		for (int i = 0; i < RSP_DELAY + 4; i++) begin
			drive_cycle(2, 1'b0);
		end
	endtask

	initial begin
		bit to_a;
		bit to_b;
		int fails;
		lfsr = 32'd68;
		pushed = 0;
		issued = 0;
		to_b = 1'b0;
		rstn = 1'b0;
		enabled_in = 1'b0;
		quiet = 1'b0;
		read_valid = 1'b0;
		write_valid = 1'b0;
		wed_valid = 1'b0;
		read_address = '0;
		write_address = '0;
		wed_address = '0;
		read_cu_id = '0;
		write_cu_id = '0;
		wed_cu_id = '0;
		rsp_valid = 1'b0;
		rsp_tag = '0;
		rsp_code = DONE;
		rsp_credits = '0;
		repeat (2) @(posedge clock);
		#2 rstn = 1'b1;
		enabled_in = 1'b1;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			drive_cycle(0, 1'b1);
		end
		drain(to_a);
		if (!to_a) begin
			// queues fill while disabled and nothing issues
			@(posedge clock);
			#2 enabled_in = 1'b0;
			quiet = 1'b1;
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				drive_cycle(1, 1'b0);
			end
			for (int i = 0; i < 6; i++) begin
				drive_cycle(2, 1'b0);
			end
			quiet = 1'b0;
			enabled_in = 1'b1;
			drain(to_b);
		end
		if (to_a || to_b) begin
			$display("timeout: commands did not issue or drain in time");
			fails = 1;
		end else begin
			afu_checker_i.check_empty();
			fails = 0;
		end
		$display("errors: %0d mismatches, %0d other, %0d timeouts (pushes %0d, issues %0d)",
			mismatch_count, other_count, fails, pushed, issued);
		if (fails == 0 && mismatch_count == 0 && other_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
rtl/psl_pkg.sv
rtl/afu_pkg.sv
rtl/class_queue.sv
rtl/cmd_arbiter.sv
rtl/tag_control.sv
rtl/credit_control.sv
rtl/rsp_route.sv
rtl/afu_control.sv
dv/afu_checker.sv
dv/tb_afu_control.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_afu_control -f tb.f
out=$(./obj_dir/Vtb_afu_control)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
